//--- tlk_line_pkg.sv
`default_nettype none

package tlk_line_pkg;

    //////////////////////////////
    // line codes
    //////////////////////////////

    // sync code, d5.6 on the msb byte
    localparam logic [7:0] k28_5_c = 8'hBC;
    localparam logic [7:0] d5_6_c  = 8'hC5;

    // frame start pair
    localparam logic [7:0] k27_7_c = 8'hFB;
    localparam logic [7:0] k28_2_c = 8'h5C;

    // both k flags with all ones means the link is down
    localparam logic [15:0] link_idle_c = 16'hFFFF;

    localparam logic [31:0] frame_head_c = 32'hEB90E116;

    //////////////////////////////
    // receive states
    //////////////////////////////

    typedef enum logic [3:0] {
        IDLE,
        SYNC,
        FRAME_HEAD,
        DATA_TYPE,
        LINE_INFO,
        DATA_LENGTH,
        RECV_DATA,
        CHECK_DATA,
        FRAME_END1,
        FRAME_END2
    } rx_state_e;

endpackage

`default_nettype wire

//--- tlk_data_pkg.sv
`default_nettype none

package tlk_data_pkg;

    // one serdes beat
    typedef logic [15:0] beat_t;

    // four beats, first beat on top
    typedef logic [63:0] word_t;

    // length in bytes, always even
    typedef logic [15:0] frame_len_t;

    typedef logic [23:0] line_num_t;
    typedef logic [3:0]  data_type_t;
    typedef logic [1:0]  channel_id_t;

endpackage

`default_nettype wire

//--- rx_frame_fsm.sv
`default_nettype none

module rx_frame_fsm
    import tlk_line_pkg::*, tlk_data_pkg::*;
(
    input  logic      i_2711_rx_clk,
    input  logic      i_rst_n,
    input  logic      i_rkmsb,
    input  logic      i_rklsb,
    input  beat_t     i_rxd,
    input  beat_t     i_rxd_prev,
    output rx_state_e o_state,
    output logic      o_payload_beat,
    output logic      o_last_payload,
    output logic      o_in_body,
    output logic      o_frame_done
);

    rx_state_e   state;
    rx_state_e   state_nxt;
    logic [14:0] half_len;
    logic [14:0] pay_cnt;
    logic        sync_hit;
    logic        start_hit;
    logic        head_hit;

    assign sync_hit  = ~i_rkmsb & i_rklsb & (i_rxd == {d5_6_c, k28_5_c});
    assign start_hit = i_rkmsb & i_rklsb & (i_rxd == {k28_2_c, k27_7_c});
    // head flag spans two beats
    assign head_hit  = ({i_rxd_prev, i_rxd} == frame_head_c);

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:        if (sync_hit) state_nxt = SYNC;
            SYNC:        if (start_hit) state_nxt = FRAME_HEAD;
            FRAME_HEAD:  if (head_hit) state_nxt = DATA_TYPE;
            DATA_TYPE:   state_nxt = LINE_INFO;
            LINE_INFO:   state_nxt = DATA_LENGTH;
            DATA_LENGTH: state_nxt = RECV_DATA;
            RECV_DATA:   if (o_last_payload) state_nxt = CHECK_DATA;
            CHECK_DATA:  state_nxt = FRAME_END1;
            FRAME_END1:  state_nxt = FRAME_END2;
            FRAME_END2:  state_nxt = IDLE;
            default:     state_nxt = IDLE;
        endcase
    end

    // length is in bytes, count in beats
    always_ff @(posedge i_2711_rx_clk) begin
        if (state == DATA_LENGTH) begin
            half_len <= i_rxd[15:1];
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            pay_cnt <= '0;
        end else if (state == RECV_DATA) begin
            pay_cnt <= pay_cnt + 15'd1;
        end else begin
            pay_cnt <= '0;
        end
    end

    assign o_state        = state;
    assign o_payload_beat = (state == RECV_DATA);
    assign o_last_payload = o_payload_beat & (pay_cnt == half_len - 15'd1);
    assign o_in_body      = (state == DATA_TYPE) | (state == LINE_INFO) |
                            (state == DATA_LENGTH) | (state == RECV_DATA) |
                            (state == CHECK_DATA);
    assign o_frame_done   = (state == FRAME_END1);

endmodule

`default_nettype wire

//--- frame_header_capture.sv
`default_nettype none

module frame_header_capture
    import tlk_line_pkg::*, tlk_data_pkg::*;
(
    input  logic        i_2711_rx_clk,
    input  logic        i_rst_n,
    input  rx_state_e   i_state,
    input  beat_t       i_rxd,
    output data_type_t  o_data_type,
    output channel_id_t o_channel_id,
    output logic        o_file_end,
    output line_num_t   o_line_number,
    output frame_len_t  o_frame_length,
    output logic        o_checksum_err
);

    beat_t checksum;

    //////////////////////////////
    // header fields
    //////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        case (i_state)
            DATA_TYPE: begin
                // bit 15 is spare
                o_file_end            <= i_rxd[14];
                o_channel_id          <= i_rxd[13:12];
                o_data_type           <= i_rxd[11:8];
                o_line_number[23:16]  <= i_rxd[7:0];
            end
            LINE_INFO: begin
                o_line_number[15:0] <= i_rxd;
            end
            DATA_LENGTH: begin
                o_frame_length <= i_rxd;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////
    // checksum
    //////////////////////////////

    // mod 2^16 sum from data type up to the last payload beat
    always_ff @(posedge i_2711_rx_clk) begin
        case (i_state)
            IDLE, SYNC, FRAME_HEAD: begin
                checksum <= '0;
            end
            DATA_TYPE, LINE_INFO, DATA_LENGTH, RECV_DATA: begin
                checksum <= checksum + i_rxd;
            end
            default: begin
            end
        endcase
    end

    // flag holds until the next frame's check beat
    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            o_checksum_err <= 1'b0;
        end else if (i_state == CHECK_DATA) begin
            o_checksum_err <= (checksum != i_rxd);
        end
    end

endmodule

`default_nettype wire

//--- payload_packer.sv
`default_nettype none

module payload_packer
    import tlk_data_pkg::*;
(
    input  logic  i_2711_rx_clk,
    input  logic  i_rst_n,
    input  beat_t i_rxd,
    input  logic  i_payload_beat,
    input  logic  i_last_payload,
    output logic  o_push,
    output word_t o_word
);

    logic [1:0] pos;
    word_t      word_sr;
    logic       word_done;

    // first beat of a word clears the rest, so a short word comes out zero padded
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_payload_beat) begin
            case (pos)
                2'd0:    word_sr        <= {i_rxd, 48'd0};
                2'd1:    word_sr[47:32] <= i_rxd;
                2'd2:    word_sr[31:16] <= i_rxd;
                default: word_sr[15:0]  <= i_rxd;
            endcase
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            pos       <= 2'd0;
            word_done <= 1'b0;
            o_push    <= 1'b0;
        end else begin
            if (i_payload_beat) begin
                // restart on a word boundary for the next frame
                pos <= i_last_payload ? 2'd0 : pos + 2'd1;
            end
            word_done <= i_payload_beat & ((pos == 2'd3) | i_last_payload);
            o_push    <= word_done;
        end
    end

    // separate output stage, word_sr is already taking the next word
    always_ff @(posedge i_2711_rx_clk) begin
        if (word_done) begin
            o_word <= word_sr;
        end
    end

endmodule

`default_nettype wire

//--- word_credit_fifo.sv
`default_nettype none

module word_credit_fifo
    import tlk_data_pkg::*;
#(
    parameter int FIFO_DEPTH = 8,
    parameter int CREDITS    = 4
) (
    input  logic  i_2711_rx_clk,
    input  logic  i_rst_n,
    input  logic  i_push,
    input  word_t i_word,
    input  logic  i_credit_return,
    output logic  o_word_valid,
    output word_t o_word_data,
    output logic  o_overflow
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int RW = $clog2(CREDITS + 1);

    word_t         mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] fill;
    logic [RW-1:0] credit;
    logic          full;
    logic          push_ok;
    logic          send;

    // depth need not be a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (fill == CW'(FIFO_DEPTH));
    assign push_ok = i_push & ~full;
    assign send    = (fill != '0) & (credit != '0);

    always_ff @(posedge i_2711_rx_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_word;
        end
        if (send) begin
            o_word_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (!i_rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            credit       <= RW'(CREDITS);
            o_word_valid <= 1'b0;
            o_overflow   <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (send) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_ok, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // send and return together cancel out
            case ({send, i_credit_return})
                2'b10:   credit <= credit - 1'b1;
                2'b01:   credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
            o_word_valid <= send;
            // serdes can't be stalled, so a push into a full FIFO is lost
            if (i_push & full) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- loss_monitor.sv
`default_nettype none

module loss_monitor
    import tlk_line_pkg::*, tlk_data_pkg::*;
#(
    parameter int HOLDOFF_CYCLES = 10000000
) (
    input  logic  i_2711_rx_clk,
    input  logic  i_rst_n,
    input  logic  i_rkmsb,
    input  logic  i_rklsb,
    input  beat_t i_rxd,
    input  logic  i_in_body,
    input  logic  i_link_loss_ena,
    input  logic  i_sync_loss_ena,
    output logic  o_link_loss,
    output logic  o_sync_loss
);

    localparam int TW = $clog2(HOLDOFF_CYCLES + 1);

    logic [1:0] det;
    logic [1:0] ena;
    logic [1:0] pulse;

    // bit 0 link loss, bit 1 sync loss
    assign det[0] = i_rkmsb & i_rklsb & (i_rxd == link_idle_c);
    assign det[1] = (i_rkmsb | i_rklsb) & i_in_body;
    assign ena    = {i_sync_loss_ena, i_link_loss_ena};

    for (genvar g = 0; g < 2; g++) begin : g_det
        logic          hold;
        logic [TW-1:0] timer;

        always_ff @(posedge i_2711_rx_clk) begin
            if (!i_rst_n || !ena[g]) begin
                pulse[g] <= 1'b0;
                hold     <= 1'b0;
                timer    <= '0;
            end else begin
                pulse[g] <= det[g] & ~hold & ~pulse[g];
                if (pulse[g]) begin
                    hold <= 1'b1;
                end else if (timer == TW'(HOLDOFF_CYCLES)) begin
                    hold <= 1'b0;
                end
                // hold-off window keeps the host from being flooded
                timer <= hold ? timer + 1'b1 : '0;
            end
        end
    end

    assign o_link_loss = pulse[0];
    assign o_sync_loss = pulse[1];

endmodule

`default_nettype wire

//--- tlk2711_rx_top.sv
`default_nettype none

module tlk2711_rx_top
    import tlk_line_pkg::*, tlk_data_pkg::*;
#(
    parameter int FIFO_DEPTH     = 8,
    parameter int CREDITS        = 4,
    parameter int HOLDOFF_CYCLES = 10000000
) (
    input  logic        i_2711_rx_clk,
    input  logic        i_rst_n,
    input  logic        i_2711_rkmsb,
    input  logic        i_2711_rklsb,
    input  beat_t       i_2711_rxd,
    input  logic        i_link_loss_ena,
    input  logic        i_sync_loss_ena,
    input  logic        i_credit_return,
    output data_type_t  o_data_type,
    output channel_id_t o_channel_id,
    output logic        o_file_end,
    output line_num_t   o_line_number,
    output frame_len_t  o_frame_length,
    output logic        o_checksum_err,
    output logic        o_frame_done,
    output logic        o_word_valid,
    output word_t       o_word_data,
    output logic        o_overflow,
    output logic        o_link_loss,
    output logic        o_sync_loss
);

    beat_t     rxd_prev;
    rx_state_e state;
    logic      payload_beat;
    logic      last_payload;
    logic      in_body;
    logic      push;
    word_t     packed_word;

    // previous beat for the two-beat head flag
    always_ff @(posedge i_2711_rx_clk) begin
        rxd_prev <= i_2711_rxd;
    end

    //////////////////////////////
    // frame parsing
    //////////////////////////////

    rx_frame_fsm fsm_i (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_rkmsb        (i_2711_rkmsb),
        .i_rklsb        (i_2711_rklsb),
        .i_rxd          (i_2711_rxd),
        .i_rxd_prev     (rxd_prev),
        .o_state        (state),
        .o_payload_beat (payload_beat),
        .o_last_payload (last_payload),
        .o_in_body      (in_body),
        .o_frame_done   (o_frame_done)
    );

    frame_header_capture hdr_i (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_state        (state),
        .i_rxd          (i_2711_rxd),
        .o_data_type    (o_data_type),
        .o_channel_id   (o_channel_id),
        .o_file_end     (o_file_end),
        .o_line_number  (o_line_number),
        .o_frame_length (o_frame_length),
        .o_checksum_err (o_checksum_err)
    );

    //////////////////////////////
    // payload path
    //////////////////////////////

    payload_packer packer_i (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_rxd          (i_2711_rxd),
        .i_payload_beat (payload_beat),
        .i_last_payload (last_payload),
        .o_push         (push),
        .o_word         (packed_word)
    );

    word_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .CREDITS    (CREDITS)
    ) fifo_i (
        .i_2711_rx_clk   (i_2711_rx_clk),
        .i_rst_n         (i_rst_n),
        .i_push          (push),
        .i_word          (packed_word),
        .i_credit_return (i_credit_return),
        .o_word_valid    (o_word_valid),
        .o_word_data     (o_word_data),
        .o_overflow      (o_overflow)
    );

    loss_monitor #(
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) loss_i (
        .i_2711_rx_clk   (i_2711_rx_clk),
        .i_rst_n         (i_rst_n),
        .i_rkmsb         (i_2711_rkmsb),
        .i_rklsb         (i_2711_rklsb),
        .i_rxd           (i_2711_rxd),
        .i_in_body       (in_body),
        .i_link_loss_ena (i_link_loss_ena),
        .i_sync_loss_ena (i_sync_loss_ena),
        .o_link_loss     (o_link_loss),
        .o_sync_loss     (o_sync_loss)
    );

endmodule

`default_nettype wire

//--- tb_tlk2711_rx.sv
`default_nettype none

module tb_tlk2711_rx
    import tlk_line_pkg::*, tlk_data_pkg::*;
();

    localparam int FIFO_DEPTH     = 8;
    localparam int CREDITS        = 4;
    localparam int HOLDOFF_CYCLES = 64;
    localparam int NUM_FRAMES     = 6;
    localparam int TOTAL_BYTES    = 882 + 16 + 2 + 16 + 64 + 16;
    localparam int MAX_CYCLES     = TOTAL_BYTES / 2 + NUM_FRAMES * 40 + 1000;
    localparam logic [31:0] SEED  = 32'h409d4d7d;

    logic        rx_clk;
    logic        rst_n;
    logic        rkmsb;
    logic        rklsb;
    beat_t       rxd;
    logic        link_ena;
    logic        sync_ena;
    logic        credit_return;
    data_type_t  data_type;
    channel_id_t channel_id;
    logic        file_end;
    line_num_t   line_number;
    frame_len_t  frame_length;
    logic        checksum_err;
    logic        frame_done;
    logic        word_valid;
    word_t       word_data;
    logic        overflow;
    logic        link_loss;
    logic        sync_loss;

    // reference model state
    word_t       exp_q[$];
    data_type_t  exp_type;
    channel_id_t exp_chan;
    logic        exp_file_end;
    line_num_t   exp_line;
    frame_len_t  exp_len;
    logic        exp_cksum_err;
    logic        hold_credits;
    logic [31:0] data_lfsr;
    int          frames_checked = 0;
    int          words_checked  = 0;
    int          owed           = 0;
    int          link_pulses    = 0;
    int          sync_pulses    = 0;
    int          cycle_cnt      = 0;

    tlk2711_rx_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .CREDITS        (CREDITS),
        .HOLDOFF_CYCLES (HOLDOFF_CYCLES)
    ) dut_i (
        .i_2711_rx_clk   (rx_clk),
        .i_rst_n         (rst_n),
        .i_2711_rkmsb    (rkmsb),
        .i_2711_rklsb    (rklsb),
        .i_2711_rxd      (rxd),
        .i_link_loss_ena (link_ena),
        .i_sync_loss_ena (sync_ena),
        .i_credit_return (credit_return),
        .o_data_type     (data_type),
        .o_channel_id    (channel_id),
        .o_file_end      (file_end),
        .o_line_number   (line_number),
        .o_frame_length  (frame_length),
        .o_checksum_err  (checksum_err),
        .o_frame_done    (frame_done),
        .o_word_valid    (word_valid),
        .o_word_data     (word_data),
        .o_overflow      (overflow),
        .o_link_loss     (link_loss),
        .o_sync_loss     (sync_loss)
    );

    initial begin
        rx_clk = 1'b0;
        forever #20 rx_clk = ~rx_clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic value_error(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        stop_run($sformatf("FAIL time %0t %s expected %0h got %0h", $time, name, exp, act));
    endtask

    task automatic step_cycle();
        @(posedge rx_clk);
        #2;
    endtask

    task automatic drive_beat(input logic mk, input logic lk, input beat_t d);
        rkmsb = mk;
        rklsb = lk;
        rxd   = d;
        step_cycle();
    endtask

    task automatic idle_beats(input int n);
        repeat (n) drive_beat(1'b0, 1'b0, 16'h0000);
    endtask

    // k_beat picks the payload beat that carries a K flag (-1 for none)
    task automatic send_frame(input frame_len_t len, input data_type_t ftype,
                              input channel_id_t chan, input logic fend,
                              input line_num_t line, input logic bad_sum, input int k_beat);
        beat_t       type_beat;
        beat_t       sum;
        beat_t       pay;
        word_t       cur;
        int          n;
        int          half;
        logic [31:0] r;
        type_beat     = {1'b0, fend, chan, ftype, line[23:16]};
        exp_type      = ftype;
        exp_chan      = chan;
        exp_file_end  = fend;
        exp_line      = line;
        exp_len       = len;
        exp_cksum_err = bad_sum;
        sum           = type_beat + line[15:0] + len;
        half          = int'(len) / 2;
        idle_beats(2);
        drive_beat(1'b0, 1'b1, {d5_6_c, k28_5_c});
        drive_beat(1'b1, 1'b1, {k28_2_c, k27_7_c});
        drive_beat(1'b0, 1'b0, frame_head_c[31:16]);
        drive_beat(1'b0, 1'b0, frame_head_c[15:0]);
        drive_beat(1'b0, 1'b0, type_beat);
        drive_beat(1'b0, 1'b0, line[15:0]);
        drive_beat(1'b0, 1'b0, len);
        cur = '0;
        n   = 0;
        for (int i = 0; i < half; i++) begin
            rand_bits(data_lfsr, 16, r);
            pay = r[15:0];
            sum = sum + pay;
            // first beat lands on top and a short last word stays zero below
            cur = cur | (word_t'(pay) << (48 - 16 * n));
            n   = n + 1;
            if (n == 4 || i == half - 1) begin
                exp_q.push_back(cur);
                cur = '0;
                n   = 0;
            end
            drive_beat(i == k_beat, 1'b0, pay);
        end
        drive_beat(1'b0, 1'b0, bad_sum ? ~sum : sum);
        idle_beats(2);
    endtask

    task automatic wait_frames(input int n);
        while (frames_checked < n) step_cycle();
    endtask

    task automatic drain_words();
        while (words_checked != exp_q.size() || owed != 0) step_cycle();
    endtask

    //////////////////////////////
    // monitors and checks
    //////////////////////////////

    always @(posedge rx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_run($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
        end
    end

    always @(posedge rx_clk) begin
        if (!rst_n) begin
            owed <= 0;
        end else begin
            owed <= owed + (word_valid ? 1 : 0) - (credit_return ? 1 : 0);
        end
    end

    always @(posedge rx_clk) begin
        if (rst_n && word_valid) begin
            word_expected: assert (words_checked < exp_q.size())
                else stop_run("word received when none was expected");
            if (words_checked < exp_q.size()) begin
                word_match: assert (word_data == exp_q[words_checked])
                    else value_error("o_word_data", exp_q[words_checked], word_data);
                words_checked <= words_checked + 1;
            end
        end
    end

    always @(posedge rx_clk) begin
        if (rst_n && frame_done) begin
            hdr_type: assert (data_type == exp_type)
                else value_error("o_data_type", 64'(exp_type), 64'(data_type));
            hdr_chan: assert (channel_id == exp_chan)
                else value_error("o_channel_id", 64'(exp_chan), 64'(channel_id));
            hdr_end: assert (file_end == exp_file_end)
                else value_error("o_file_end", 64'(exp_file_end), 64'(file_end));
            hdr_line: assert (line_number == exp_line)
                else value_error("o_line_number", 64'(exp_line), 64'(line_number));
            hdr_len: assert (frame_length == exp_len)
                else value_error("o_frame_length", 64'(exp_len), 64'(frame_length));
            hdr_sum: assert (checksum_err == exp_cksum_err)
                else value_error("o_checksum_err", 64'(exp_cksum_err), 64'(checksum_err));
            frames_checked <= frames_checked + 1;
        end
    end

    always @(posedge rx_clk) begin
        if (rst_n) begin
            if (link_loss) begin
                link_pulses <= link_pulses + 1;
            end
            if (sync_loss) begin
                sync_pulses <= sync_pulses + 1;
            end
        end
    end

    no_overflow: assert property (@(posedge rx_clk) disable iff (!rst_n) !overflow)
        else value_error("o_overflow", 64'd0, 64'(overflow));

    credit_bound: assert property (@(posedge rx_clk) disable iff (!rst_n) owed <= CREDITS)
        else stop_run($sformatf("more than %0d words outstanding at time %0t", CREDITS, $time));

    link_single: assert property (@(posedge rx_clk) disable iff (!rst_n)
                                  link_loss |=> !link_loss)
        else stop_run("o_link_loss stayed high for more than one cycle");

    // credit sink returns one credit per received word after a short random gap
    initial begin : credit_sink
        logic [31:0] gap_lfsr;
        logic [31:0] gap;
        gap_lfsr      = SEED;
        credit_return = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge rx_clk);
            if (!hold_credits && owed > 0) begin
                rand_bits(gap_lfsr, 1, gap);
                repeat (gap) @(posedge rx_clk);
                #2;
                credit_return = 1'b1;
                step_cycle();
                credit_return = 1'b0;
            end
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        rst_n        = 1'b0;
        rkmsb        = 1'b0;
        rklsb        = 1'b0;
        rxd          = '0;
        link_ena     = 1'b0;
        sync_ena     = 1'b0;
        hold_credits = 1'b0;
        data_lfsr    = SEED;
        repeat (4) @(posedge rx_clk);
        #2;
        rst_n = 1'b1;

        // payload packing with a long frame and two short ones
        send_frame(16'd882, 4'h3, 2'd1, 1'b0, 24'h12A5C3, 1'b0, -1);
        send_frame(16'd16, 4'hC, 2'd3, 1'b1, 24'h00FF01, 1'b0, -1);
        send_frame(16'd2, 4'h5, 2'd0, 1'b0, 24'hABCDEF, 1'b0, -1);
        wait_frames(3);
        drain_words();

        // corrupted checksum beat
        send_frame(16'd16, 4'hA, 2'd2, 1'b1, 24'hF00001, 1'b1, -1);
        wait_frames(4);
        drain_words();

        // sink stops returning credits to build back-pressure
        hold_credits = 1'b1;
        send_frame(16'd64, 4'h1, 2'd1, 1'b0, 24'h000100, 1'b0, -1);
        wait_frames(5);
        while (owed != CREDITS) step_cycle();
        repeat (20) step_cycle();
        held_words: assert (exp_q.size() - words_checked == 8 - CREDITS)
            else stop_run("words left the FIFO while no credits were returned");
        hold_credits = 1'b0;
        drain_words();

        // link loss with hold-off
        link_ena = 1'b1;
        // two back-to-back link beats still give one pulse
        drive_beat(1'b1, 1'b1, link_idle_c);
        drive_beat(1'b1, 1'b1, link_idle_c);
        idle_beats(3);
        link_first: assert (link_pulses == 1)
            else value_error("o_link_loss pulses", 64'd1, 64'(link_pulses));
        idle_beats(10);
        drive_beat(1'b1, 1'b1, link_idle_c);
        idle_beats(3);
        link_held: assert (link_pulses == 1)
            else value_error("o_link_loss pulses", 64'd1, 64'(link_pulses));
        idle_beats(150);
        drive_beat(1'b1, 1'b1, link_idle_c);
        idle_beats(3);
        link_again: assert (link_pulses == 2)
            else value_error("o_link_loss pulses", 64'd2, 64'(link_pulses));

        // K flag while idle must not raise sync loss
        sync_ena = 1'b1;
        drive_beat(1'b1, 1'b0, 16'h1234);
        idle_beats(3);
        sync_idle: assert (sync_pulses == 0)
            else value_error("o_sync_loss pulses", 64'd0, 64'(sync_pulses));
        send_frame(16'd16, 4'h7, 2'd2, 1'b0, 24'h0A0B0C, 1'b0, 2);
        wait_frames(6);
        drain_words();
        sync_body: assert (sync_pulses == 1)
            else value_error("o_sync_loss pulses", 64'd1, 64'(sync_pulses));

        if (frames_checked == NUM_FRAMES && words_checked == exp_q.size()) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_run("run ended before every frame and word was checked");
        end
    end

endmodule

`default_nettype wire

//--- src.f
tlk_line_pkg.sv
tlk_data_pkg.sv
rx_frame_fsm.sv
frame_header_capture.sv
payload_packer.sv
word_credit_fifo.sv
loss_monitor.sv
tlk2711_rx_top.sv
tb_tlk2711_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the tlk2711 receive testbench with verilator, run it, check the log
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -j 0 --top-module tb_tlk2711_rx \
        -f src.f -o sim_tlk2711 \
    && { ./obj_dir/sim_tlk2711 | tee sim.log; true; } \
    && grep -q "SIMULATION PASSED" sim.log \
    && echo "run ok" \
    || { echo "run not ok"; exit 1; }
